// File: fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;          // Fetch address
    typedef logic [31:0] instr_t;         // Instruction word
    typedef logic [6:0]  ecc_t;           // SECDED checksum or syndrome
    typedef logic [63:0] axi_data_t;      // AXI read data beat
    typedef logic [2:0]  fetch_status_t;  // Status stored with each entry
    typedef logic [1:0]  pred_t;          // RAS prediction
    typedef logic [36:0] ifb_entry_t;     // {pred, status, instr}

    localparam int IFB_DEPTH       = 4;   // Default buffer depth
    localparam int MAX_OUTSTANDING = 2;   // Read credit of the fetch master

    // Wide enough for occupancy plus outstanding reads
    typedef logic [$clog2(IFB_DEPTH + MAX_OUTSTANDING + 1)-1:0] cnt_t;

    // Entry layout
    localparam int ENTRY_PRED_HI  = 36;
    localparam int ENTRY_PRED_LO  = 35;
    localparam int ENTRY_STAT_HI  = 34;
    localparam int ENTRY_STAT_LO  = 32;
    localparam int ENTRY_INSTR_HI = 31;

    // Checksum position inside an AXI beat
    localparam int AXI_ECC_HI = 38;
    localparam int AXI_ECC_LO = 32;

    localparam fetch_status_t FETCH_VALID  = 3'b001;  // OKAY, no error seen
    localparam fetch_status_t FETCH_BUSERR = 3'b010;  // SLVERR or DECERR
    localparam fetch_status_t FETCH_INCER  = 3'b011;  // Corrected single-bit error
    localparam fetch_status_t FETCH_INUCE  = 3'b100;  // Uncorrectable error

    localparam pred_t PRED_NONE = 2'b00;  // No RAS update

    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;
    localparam logic [2:0] AXI_PROT_FETCH = 3'b100;  // Instruction, secure, unprivileged

    localparam addr_t RESET_ADDR = 32'h0000_0000;  // First fetch after reset

    typedef enum logic {
        FS_IDLE,  // Waiting one cycle out of reset
        FS_RUN    // Issuing reads
    } fetch_state_t;

    // Hsiao matrix, one weight-3 column per data bit
    // Checksum bits use the unit columns
    localparam ecc_t HSIAO_COL [32] = '{
        7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,
        7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,
        7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,
        7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38
    };

    // XOR of the columns of all set data bits
    function automatic ecc_t secded_checksum(input instr_t data);
        ecc_t chk;
        chk = '0;
        for (int i = 0; i < 32; i++) begin
            if (data[i]) begin
                chk = chk ^ HSIAO_COL[i];
            end
        end
        return chk;
    endfunction

endpackage

// File: secded_check.sv
module secded_check (
    input  fetch_pkg::ecc_t   syndrome_i,  // Recomputed XOR stored checksum
    input  fetch_pkg::instr_t data_i,      // Raw word of entry 0
    output fetch_pkg::instr_t data_o,      // Word with a single data bit repaired
    output logic              error_o,     // Any error present
    output logic              ce_o         // Error is correctable
);
    import fetch_pkg::*;

    logic data_hit;   // Syndrome names a data bit
    logic check_hit;  // Syndrome names a checksum bit

    // Match against every data column
    always_comb begin
        data_o   = data_i;
        data_hit = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (syndrome_i == HSIAO_COL[i]) begin
                data_o[i] = ~data_i[i];  // Flip the faulty bit
                data_hit  = 1'b1;
            end
        end
    end

    // Unit syndrome means the stored checksum itself took the hit
    always_comb begin
        check_hit = 1'b0;
        for (int j = 0; j < 7; j++) begin
            if (syndrome_i == ecc_t'(1 << j)) begin
                check_hit = 1'b1;
            end
        end
    end

    // Zero syndrome is a clean word
    assign error_o = (syndrome_i != '0);

    // Even weight or an unused odd column stays uncorrectable
    assign ce_o    = data_hit | check_hit;

endmodule

// File: fetch_axi_master.sv
module fetch_axi_master (
    input  logic                             s_clk_i,
    input  logic                             arst_n_i,
    input  logic                             redirect_i,       // Restart fetching
    input  fetch_pkg::addr_t                 redirect_addr_i,  // New fetch address
    // AR channel
    output logic                             m_arvalid_o,
    input  logic                             m_arready_i,
    output fetch_pkg::addr_t                 m_araddr_o,
    output logic [2:0]                       m_arprot_o,
    // R channel
    input  logic                             m_rvalid_i,
    output logic                             m_rready_o,
    input  fetch_pkg::axi_data_t             m_rdata_i,
    input  logic [1:0]                       m_rresp_i,
    // Buffer side
    output logic                             push_o,
    output fetch_pkg::ifb_entry_t            entry_o,
    output fetch_pkg::ecc_t                  checksum_o,
    input  logic [fetch_pkg::IFB_DEPTH-1:0]  occupied_i
);
    import fetch_pkg::*;

    fetch_state_t  state_q;
    addr_t         pc_q;        // Next address to issue
    addr_t         araddr_q;
    logic          arvalid_q;
    logic          ar_stale_q;  // Pending AR predates a redirect
    cnt_t          live_q;      // Outstanding reads of the current stream
    cnt_t          stale_q;     // Outstanding reads to drop
    cnt_t          occ_cnt;
    cnt_t          live_pend;
    cnt_t          total_cnt;
    logic          ar_fire;
    logic          r_fire;
    logic          issue;
    fetch_status_t r_status;

    assign ar_fire = arvalid_q & m_arready_i;
    assign r_fire  = m_rvalid_i;  // rready is always high

    // Occupied entries of the buffer
    always_comb begin
        occ_cnt = '0;
        for (int i = 0; i < IFB_DEPTH; i++) begin
            occ_cnt = occ_cnt + cnt_t'(occupied_i[i]);
        end
    end

    assign live_pend = live_q + cnt_t'(arvalid_q & ~ar_stale_q);  // Needs room in the buffer
    assign total_cnt = live_q + stale_q + cnt_t'(arvalid_q);      // Every read in flight

    // New AR only with buffer room and read credit left
    assign issue = (state_q == FS_RUN) & ~redirect_i & (~arvalid_q | ar_fire)
                 & (occ_cnt + live_pend < cnt_t'(IFB_DEPTH))
                 & (total_cnt < cnt_t'(MAX_OUTSTANDING));

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= FS_IDLE;
            pc_q       <= RESET_ADDR;
            arvalid_q  <= 1'b0;
            ar_stale_q <= 1'b0;
            live_q     <= '0;
            stale_q    <= '0;
        end else begin
            if (state_q == FS_IDLE) state_q <= FS_RUN;  // One quiet cycle after reset
            if (redirect_i) begin
                pc_q <= redirect_addr_i;
            end else if (issue) begin
                pc_q <= pc_q + 32'd4;  // Word-sequential fetch
            end
            if (issue) begin
                arvalid_q <= 1'b1;
            end else if (ar_fire) begin
                arvalid_q <= 1'b0;
            end
            // AR held across a redirect keeps its address but goes stale
            if (redirect_i && arvalid_q && !m_arready_i) begin
                ar_stale_q <= 1'b1;
            end else if (ar_fire) begin
                ar_stale_q <= 1'b0;
            end
            if (redirect_i) begin
                live_q  <= '0;  // Whole stream becomes stale
                stale_q <= stale_q + live_q + cnt_t'(ar_fire) - cnt_t'(r_fire);
            end else begin
                live_q  <= live_q + cnt_t'(ar_fire & ~ar_stale_q)
                         - cnt_t'(r_fire & (stale_q == '0));
                stale_q <= stale_q + cnt_t'(ar_fire & ar_stale_q)
                         - cnt_t'(r_fire & (stale_q != '0));  // Stale beats come first
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (issue) araddr_q <= pc_q;
    end

    assign m_arvalid_o = arvalid_q;
    assign m_araddr_o  = araddr_q;
    assign m_arprot_o  = AXI_PROT_FETCH;
    assign m_rready_o  = 1'b1;

    // Status from the response code
    assign r_status   = (m_rresp_i == AXI_RESP_OKAY) ? FETCH_VALID : FETCH_BUSERR;
    assign push_o     = r_fire & (stale_q == '0) & ~redirect_i;
    assign entry_o    = {PRED_NONE, r_status, m_rdata_i[31:0]};
    assign checksum_o = m_rdata_i[AXI_ECC_HI:AXI_ECC_LO];

    // AXI rule on a waiting address
    a_araddr_stable: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

    // Reads in flight stay within the credit
    a_credit: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        total_cnt <= cnt_t'(MAX_OUTSTANDING));

endmodule

// File: ifb.sv
module ifb #(
    parameter int SIZE = fetch_pkg::IFB_DEPTH  // Two or more entries
) (
    input  logic                  s_clk_i,
    input  logic                  arst_n_i,
    input  logic                  s_flush_i,       // Drop every entry
    input  logic                  s_push_i,        // New entry into slot 0
    input  logic                  s_pop_i,         // Consumer takes the output
    input  fetch_pkg::pred_t      s_ras_pred_i,    // RAS update of slot 0
    input  fetch_pkg::ifb_entry_t s_data_i,
    input  fetch_pkg::ecc_t       s_checksum_i,
    output fetch_pkg::ecc_t       syndrome_o,      // To the SECDED checker
    input  fetch_pkg::instr_t     corrected_i,     // Back from the checker
    input  logic                  ce_i,
    input  logic                  error_i,
    output logic                  s_valid_o,
    output fetch_pkg::ifb_entry_t s_data_o,        // Oldest entry
    output fetch_pkg::ifb_entry_t s_last_entry_o,  // Newest entry
    output logic [SIZE-1:0]       s_occupied_o
);
    import fetch_pkg::*;

    ifb_entry_t      buf_q [SIZE];  // Slot 0 is the newest
    ifb_entry_t      ubuf  [SIZE];  // Slots after update and correction
    ecc_t            chk_q;         // Checksum of slot 0
    logic [SIZE-1:0] occ_q;         // Thermometer from slot 0 up
    logic [SIZE-1:0] occ_d;
    logic            check_en;
    logic            bad;
    logic            pop;
    pred_t           pred0;

    // Recompute the checksum of slot 0 and compare with the stored one
    assign syndrome_o = secded_checksum(buf_q[0][ENTRY_INSTR_HI:0]) ^ chk_q;

    // Only a clean fetch is checked so each word is flagged once
    assign check_en = occ_q[0] & (buf_q[0][ENTRY_STAT_HI:ENTRY_STAT_LO] == FETCH_VALID);
    assign bad      = check_en & error_i;

    // Nonzero RAS prediction wins over the stored one
    assign pred0 = (s_ras_pred_i != PRED_NONE) ? s_ras_pred_i
                                                : buf_q[0][ENTRY_PRED_HI:ENTRY_PRED_LO];

    always_comb begin
        ubuf[0] = buf_q[0];
        ubuf[0][ENTRY_PRED_HI:ENTRY_PRED_LO] = pred0;
        if (bad) begin
            // Checker leaves the word alone on an uncorrectable error
            ubuf[0][ENTRY_INSTR_HI:0] = corrected_i;
            ubuf[0][ENTRY_STAT_HI:ENTRY_STAT_LO] = ce_i ? FETCH_INCER : FETCH_INUCE;
        end
        for (int i = 1; i < SIZE; i++) begin
            ubuf[i] = buf_q[i];  // Older slots pass as stored
        end
    end

    // Highest occupied slot is the oldest
    always_comb begin
        s_data_o = ubuf[0];
        for (int i = 1; i < SIZE; i++) begin
            if (occ_q[i]) s_data_o = ubuf[i];
        end
    end

    // A lone faulty entry waits one cycle for its write-back
    assign s_valid_o = occ_q[0] & (~bad | occ_q[1]);
    assign pop       = s_pop_i & s_valid_o;

    always_comb begin
        if (s_flush_i) begin
            occ_d = '0;
        end else if (s_push_i && !pop) begin
            occ_d = {occ_q[SIZE-2:0], 1'b1};  // Grow by one
        end else if (!s_push_i && pop) begin
            occ_d = {1'b0, occ_q[SIZE-1:1]};  // Shrink by one
        end else begin
            occ_d = occ_q;  // Push with pop keeps the count
        end
    end

    // Payload shifts up on a push, slot 0 takes back its update otherwise
    always_ff @(posedge s_clk_i) begin
        buf_q[0] <= s_push_i ? s_data_i : ubuf[0];
        for (int i = 1; i < SIZE; i++) begin
            if (s_push_i && occ_q[i-1]) begin
                buf_q[i] <= ubuf[i-1];
            end
        end
        if (s_push_i) chk_q <= s_checksum_i;
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_d;
        end
    end

    assign s_last_entry_o = buf_q[0];
    assign s_occupied_o   = occ_q;

    // Fetch credit must keep a full buffer from taking a push
    a_no_overflow: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        s_push_i && (&occ_q) |-> pop);

endmodule

// File: fetch_top.sv
module fetch_top (
    input  logic                     s_clk_i,
    input  logic                     arst_n_i,
    // Redirect from the core
    input  logic                     redirect_i,
    input  fetch_pkg::addr_t         redirect_addr_i,
    // Consumer side
    input  logic                     pop_i,
    input  fetch_pkg::pred_t         ras_pred_i,
    output logic                     instr_valid_o,
    output fetch_pkg::instr_t        instr_o,
    output fetch_pkg::fetch_status_t status_o,
    output fetch_pkg::pred_t         pred_o,
    output fetch_pkg::ifb_entry_t    last_entry_o,
    // AXI4-Lite read channels
    output logic                     m_arvalid_o,
    input  logic                     m_arready_i,
    output fetch_pkg::addr_t         m_araddr_o,
    output logic [2:0]               m_arprot_o,
    input  logic                     m_rvalid_i,
    output logic                     m_rready_o,
    input  fetch_pkg::axi_data_t     m_rdata_i,
    input  logic [1:0]               m_rresp_i
);
    import fetch_pkg::*;

    logic                 push;
    ifb_entry_t           entry;
    ecc_t                 checksum;
    logic [IFB_DEPTH-1:0] occupied;
    ecc_t                 syndrome;
    instr_t               corrected;
    logic                 ce;
    logic                 error;
    ifb_entry_t           ifb_data;  // Oldest entry

    fetch_axi_master u_master (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i),
        .redirect_i(redirect_i), .redirect_addr_i(redirect_addr_i),
        .m_arvalid_o(m_arvalid_o), .m_arready_i(m_arready_i),
        .m_araddr_o(m_araddr_o), .m_arprot_o(m_arprot_o),
        .m_rvalid_i(m_rvalid_i), .m_rready_o(m_rready_o),
        .m_rdata_i(m_rdata_i), .m_rresp_i(m_rresp_i),
        .push_o(push), .entry_o(entry), .checksum_o(checksum), .occupied_i(occupied)
    );

    ifb #(.SIZE(IFB_DEPTH)) u_ifb (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i), .s_flush_i(redirect_i),
        .s_push_i(push), .s_pop_i(pop_i), .s_ras_pred_i(ras_pred_i),
        .s_data_i(entry), .s_checksum_i(checksum),
        .syndrome_o(syndrome), .corrected_i(corrected), .ce_i(ce), .error_i(error),
        .s_valid_o(instr_valid_o), .s_data_o(ifb_data),
        .s_last_entry_o(last_entry_o), .s_occupied_o(occupied)
    );

    // Checks the raw word held in slot 0
    secded_check u_check (
        .syndrome_i(syndrome), .data_i(last_entry_o[ENTRY_INSTR_HI:0]),
        .data_o(corrected), .error_o(error), .ce_o(ce)
    );

    assign instr_o  = ifb_data[ENTRY_INSTR_HI:0];
    assign status_o = ifb_data[ENTRY_STAT_HI:ENTRY_STAT_LO];
    assign pred_o   = ifb_data[ENTRY_PRED_HI:ENTRY_PRED_LO];

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem (
    input  logic                 s_clk_i,
    input  logic                 arst_n_i,
    input  fetch_pkg::addr_t     err_addr_i,  // Answered with SLVERR
    // AR channel
    input  logic                 arvalid_i,
    output logic                 arready_o,
    input  fetch_pkg::addr_t     araddr_i,
    // R channel
    output logic                 rvalid_o,
    input  logic                 rready_i,
    output fetch_pkg::axi_data_t rdata_o,
    output logic [1:0]           rresp_o
);
    import fetch_pkg::*;

    localparam int WORDS      = 1024;  // Covers 0x000 to 0xFFC
    localparam int RESP_DELAY = 3;     // Cycles from AR transfer to R beat

    instr_t mem_word [WORDS];  // Clean image
    ecc_t   mem_ecc  [WORDS];  // Stored checksums
    instr_t fault    [WORDS];  // XOR mask applied on read
    addr_t  pend_addr [$];     // Accepted reads in order
    int     pend_due  [$];     // Cycle at which each read may answer
    addr_t  rd_addr;
    int     idx;
    int     cyc;

    always @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= 2'b00;
            pend_addr.delete();
            pend_due.delete();
            cyc = 0;
        end else begin
            cyc = cyc + 1;
            arready_o <= (cyc % 7) != 3;  // Stall AR one cycle in seven
            if (arvalid_i && arready_o) begin
                pend_addr.push_back(araddr_i);
                pend_due.push_back(cyc + RESP_DELAY);
            end
            if (rvalid_o && !rready_i) begin
                rvalid_o <= 1'b1;  // Hold the beat
            end else if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
                rd_addr = pend_addr.pop_front();
                void'(pend_due.pop_front());
                idx      = int'(rd_addr[11:2]);
                rvalid_o <= 1'b1;
                if (rd_addr == err_addr_i) begin
                    rdata_o <= '0;     // No data with an error response
                    rresp_o <= 2'b10;  // SLVERR
                end else begin
                    // Checksum in 38:32 and the fault mask on the data half only
                    rdata_o <= {25'b0, mem_ecc[idx], mem_word[idx] ^ fault[idx]};
                    rresp_o <= 2'b00;
                end
            end else begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// File: tb_fetch.sv
module tb_fetch;
    import fetch_pkg::*;

    localparam int TOTAL_WORDS    = 41;  // Words checked over all tests
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20;

    logic          clk;
    logic          arst_n;
    logic          redirect;
    addr_t         redirect_addr;
    logic          pop;
    pred_t         ras_pred;
    logic          instr_valid;
    instr_t        instr;
    fetch_status_t status;
    pred_t         pred;
    ifb_entry_t    last_entry;
    logic          arvalid;
    logic          arready;
    addr_t         araddr;
    logic [2:0]    arprot;
    logic          rvalid;
    logic          rready;
    axi_data_t     rdata;
    logic [1:0]    rresp;
    addr_t         err_addr;      // Address the memory answers with SLVERR
    addr_t         exp_addr [$];  // Model queue in fetch order
    pred_t         exp_pred [$];
    logic [31:0]   lcg_state;
    int            errors   = 0;
    int            cycles   = 0;
    int            ar_count = 0;  // AR transfers since the last redirect

    fetch_top u_dut (
        .s_clk_i(clk), .arst_n_i(arst_n),
        .redirect_i(redirect), .redirect_addr_i(redirect_addr),
        .pop_i(pop), .ras_pred_i(ras_pred), .instr_valid_o(instr_valid),
        .instr_o(instr), .status_o(status), .pred_o(pred), .last_entry_o(last_entry),
        .m_arvalid_o(arvalid), .m_arready_i(arready), .m_araddr_o(araddr),
        .m_arprot_o(arprot),
        .m_rvalid_i(rvalid), .m_rready_o(rready), .m_rdata_i(rdata), .m_rresp_i(rresp)
    );

    tb_axi_mem u_mem (
        .s_clk_i(clk), .arst_n_i(arst_n), .err_addr_i(err_addr),
        .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (redirect) begin
            ar_count <= 0;  // Reads up to the redirect are stale
        end else if (arvalid && arready) begin
            ar_count <= ar_count + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d", errors);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random image with a checksum per word and no fault
    task automatic fill_memory();
        lcg_state = 32'h9852_8dae;
        for (int i = 0; i < 1024; i++) begin
            lcg_state         = lcg_next(lcg_state);
            u_mem.mem_word[i] = lcg_state;
            u_mem.mem_ecc[i]  = secded_checksum(lcg_state);
            u_mem.fault[i]    = '0;
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input fetch_status_t got,
                                input fetch_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pred(input string name, input pred_t got, input pred_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_prot(input string name, input logic [2:0] got,
                              input logic [2:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // AXI side outputs between clock edges
    always @(negedge clk) begin
        if (arvalid) begin
            check_prot("m_arprot_o", arprot, 3'b100);  // Instruction, secure, unprivileged
        end
        check_flag("m_rready_o", rready, 1'b1);
    end

    // Expected word from the image, the fault mask and the error address
    task automatic check_word();
        addr_t         a;
        instr_t        w;
        instr_t        f;
        fetch_status_t st;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("Word %h came out while no word was expected", instr);
        end else begin
            a  = exp_addr.pop_front();
            w  = u_mem.mem_word[a[11:2]];
            f  = u_mem.fault[a[11:2]];
            st = FETCH_VALID;
            if (a == err_addr) begin
                w  = '0;
                st = FETCH_BUSERR;
            end else if ($countones(f) == 1) begin
                st = FETCH_INCER;  // Repaired back to the clean word
            end else if (f != '0) begin
                w  = w ^ f;        // Raw word passes through
                st = FETCH_INUCE;
            end
            check_instr("instr_o", instr, w);
            check_status("status_o", status, st);
            check_pred("pred_o", pred, exp_pred.pop_front());
        end
    endtask

    task automatic redirect_to(input addr_t a);
        @(negedge clk);
        pop           = 1'b0;
        redirect      = 1'b1;
        redirect_addr = a;
        @(negedge clk);
        redirect = 1'b0;
        exp_addr.delete();
        exp_pred.delete();
    endtask

    task automatic expect_seq(input addr_t start, input int n, input pred_t first_pred);
        for (int i = 0; i < n; i++) begin
            exp_addr.push_back(start + addr_t'(4 * i));
            exp_pred.push_back(i == 0 ? first_pred : PRED_NONE);
        end
    endtask

    // Pop n words and check each one before it leaves at the next rising edge
    task automatic consume(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            pop = 1'b1;
            if (instr_valid) begin
                check_word();
                got++;
            end
        end
        @(negedge clk);
        pop = 1'b0;
    endtask

    task automatic wait_full();
        while (!(&u_dut.occupied)) @(negedge clk);
    endtask

    task automatic test_sequential();
        expect_seq(RESET_ADDR, 16, PRED_NONE);
        consume(16);
    endtask

    task automatic test_backpressure();
        redirect_to(32'h0000_0500);
        while (!instr_valid) @(negedge clk);  // First word with pop_i low
        wait_full();
        if (ar_count > IFB_DEPTH) begin
            errors++;
            $display("%0d reads accepted with room for only %0d", ar_count, IFB_DEPTH);
        end
        if (arvalid) begin
            errors++;
            $display("AR still requested with a full buffer");
        end
        expect_seq(32'h0000_0500, 8, PRED_NONE);
        consume(8);
    endtask

    task automatic test_ecc();
        u_mem.fault[64] = 32'h0000_0020;  // 0x100, one data bit
        u_mem.fault[65] = 32'h0002_0008;  // 0x104, two data bits
        u_mem.fault[67] = 32'h8000_0000;  // 0x10C, top bit
        redirect_to(32'h0000_0100);       // Lone faulty entry first
        expect_seq(32'h0000_0100, 4, PRED_NONE);
        consume(4);
    endtask

    task automatic test_buserr();
        err_addr = 32'h0000_0208;
        redirect_to(32'h0000_0200);
        expect_seq(32'h0000_0200, 4, PRED_NONE);
        consume(4);
        err_addr = 32'hFFFF_FFFF;
    endtask

    task automatic test_redirect();
        redirect_to(32'h0000_0300);
        expect_seq(32'h0000_0300, 3, PRED_NONE);
        consume(3);
        redirect_to(32'h0000_0080);  // Later reads of the old stream still in flight
        expect_seq(32'h0000_0080, 4, PRED_NONE);
        consume(4);
    endtask

    task automatic test_prediction();
        addr_t last_addr;
        last_addr = 32'h0000_0400 + addr_t'(4 * (IFB_DEPTH - 1));
        redirect_to(32'h0000_0400);
        while (u_dut.occupied != {{(IFB_DEPTH - 1){1'b0}}, 1'b1}) @(negedge clk);
        ras_pred = 2'b10;  // Word sits alone in slot 0
        @(negedge clk);
        ras_pred = PRED_NONE;
        wait_full();
        check_instr("last_entry_o", last_entry[ENTRY_INSTR_HI:0],
                    u_mem.mem_word[last_addr[11:2]]);
        check_status("last_entry_o", last_entry[ENTRY_STAT_HI:ENTRY_STAT_LO], FETCH_VALID);
        expect_seq(32'h0000_0400, 2, 2'b10);
        consume(2);
    endtask

    initial begin
        arst_n        = 1'b0;
        redirect      = 1'b0;
        redirect_addr = '0;
        pop           = 1'b0;
        ras_pred      = PRED_NONE;
        err_addr      = 32'hFFFF_FFFF;  // No error address yet
        fill_memory();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_sequential();
        test_backpressure();
        test_ecc();
        test_buserr();
        test_redirect();
        test_prediction();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: all.f
fetch_pkg.sv
secded_check.sv
fetch_axi_master.sv
ifb.sv
fetch_top.sv
tb_axi_mem.sv
tb_fetch.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
